// ==== rtl/cpuPkg.sv ====
package cpuPkg;

    localparam int XLEN = 32;
    localparam int NUM_REGS = 32;

    typedef logic [XLEN-1:0] word_t;    // Data, address and instruction word
    typedef logic [4:0] regAddr_t;
    typedef logic [3:0] aluOp_t;        // {funct7[5], funct3} style encoding

    // ALU operation codes
    localparam aluOp_t ALU_ADD = 4'b0000;
    localparam aluOp_t ALU_SUB = 4'b1000;
    localparam aluOp_t ALU_SLT = 4'b0010;
    localparam aluOp_t ALU_XOR = 4'b0100;
    localparam aluOp_t ALU_OR = 4'b0110;
    localparam aluOp_t ALU_AND = 4'b0111;

    // Major opcodes, instr[6:0]
    localparam logic [6:0] OP_RTYPE = 7'b0110011;
    localparam logic [6:0] OP_ITYPE = 7'b0010011;
    localparam logic [6:0] OP_LOAD = 7'b0000011;
    localparam logic [6:0] OP_STORE = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;

    // funct3 codes for arithmetic and logic
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    // Branch funct3, beq is 3'b000
    localparam logic [2:0] F3_BNE = 3'b001;

    // Memory depths in words
    localparam int IMEM_WORDS = 64;
    localparam int DMEM_WORDS = 64;
    localparam int IMEM_AW = $clog2(IMEM_WORDS);
    localparam int DMEM_AW = $clog2(DMEM_WORDS);

    localparam word_t PC_STEP = 32'd4;

endpackage

// ==== rtl/ctrlIf.sv ====
`timescale 1ns/1ps

// Decoded control, decoder to datapath
interface ctrlIf;
    logic regWrite;
    logic aluSrc;               // Immediate as ALU operand b
    logic memWrite;
    logic memToReg;             // Load data as writeback source
    logic branch;
    logic branchNe;             // Set for bne, clear for beq
    cpuPkg::aluOp_t aluOp;
    cpuPkg::word_t imm;

    modport dec (
        output regWrite, aluSrc, memWrite, memToReg,
        output branch, branchNe, aluOp, imm
    );

    modport dp (
        input regWrite, aluSrc, memWrite, memToReg,
        input branch, branchNe, aluOp, imm
    );
endinterface

// ==== rtl/instMem.sv ====
`timescale 1ns/1ps

module instMem (
    input cpuPkg::word_t addr,
    output cpuPkg::word_t data
);

    cpuPkg::word_t mem [cpuPkg::IMEM_WORDS];
    logic [29:0] wordIdx;
    logic inRange;

    // Clear first so a short program.hex leaves no X words
    initial begin
        for (int i = 0; i < cpuPkg::IMEM_WORDS; i++) begin
            mem[i] = '0;
        end
        $readmemh("program.hex", mem);
    end

    assign wordIdx = addr[31:2];    // Byte address to word index
    assign inRange = (wordIdx < 30'(cpuPkg::IMEM_WORDS));

    assign data = inRange ? mem[wordIdx[cpuPkg::IMEM_AW-1:0]] : '0;

endmodule

// ==== rtl/regFile.sv ====
`timescale 1ns/1ps

module regFile (
    input logic CLK,
    input logic rst,
    input cpuPkg::regAddr_t rs1,
    input cpuPkg::regAddr_t rs2,
    input cpuPkg::regAddr_t rd,
    input cpuPkg::word_t wd,
    input logic we,
    output cpuPkg::word_t rd1,
    output cpuPkg::word_t rd2
);

    // x1..x31 only, x0 has no storage
    cpuPkg::word_t regs [1:cpuPkg::NUM_REGS-1];

    always_ff @(posedge CLK) begin
        if (rst) begin
            for (int i = 1; i < cpuPkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd != '0)) begin
            regs[rd] <= wd;
        end
    end

    // Combinational reads
    assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== rtl/decoder.sv ====
`timescale 1ns/1ps

module decoder (
    input cpuPkg::word_t instr,
    ctrlIf.dec ctrl
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic isSub;                    // funct7 bit 30
    cpuPkg::word_t immI;
    cpuPkg::word_t immS;
    cpuPkg::word_t immB;
    cpuPkg::aluOp_t arithOp;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign isSub = instr[30];

    // Sign-extended immediates
    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

    // ALU control shared by R-type and I-type
    always_comb begin
        case (funct3)
            cpuPkg::F3_ADD: arithOp = (isSub && opcode == cpuPkg::OP_RTYPE) ?
                                      cpuPkg::ALU_SUB : cpuPkg::ALU_ADD;
            cpuPkg::F3_SLT: arithOp = cpuPkg::ALU_SLT;
            cpuPkg::F3_XOR: arithOp = cpuPkg::ALU_XOR;
            cpuPkg::F3_OR: arithOp = cpuPkg::ALU_OR;
            cpuPkg::F3_AND: arithOp = cpuPkg::ALU_AND;
            default: arithOp = cpuPkg::ALU_ADD;    // Shifts not supported
        endcase
    end

    // Main control
    always_comb begin
        ctrl.regWrite = 1'b0;
        ctrl.aluSrc = 1'b0;
        ctrl.memWrite = 1'b0;
        ctrl.memToReg = 1'b0;
        ctrl.branch = 1'b0;
        ctrl.branchNe = 1'b0;
        ctrl.aluOp = cpuPkg::ALU_ADD;
        ctrl.imm = immI;
        case (opcode)
            cpuPkg::OP_RTYPE: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp = arithOp;
            end
            cpuPkg::OP_ITYPE: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc = 1'b1;
                ctrl.aluOp = arithOp;
            end
            cpuPkg::OP_LOAD: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc = 1'b1;
                ctrl.memToReg = 1'b1;
            end
            cpuPkg::OP_STORE: begin
                ctrl.aluSrc = 1'b1;
                ctrl.memWrite = 1'b1;
                ctrl.imm = immS;
            end
            cpuPkg::OP_BRANCH: begin
                ctrl.branch = 1'b1;
                ctrl.branchNe = (funct3 == cpuPkg::F3_BNE);
                ctrl.aluOp = cpuPkg::ALU_SUB;   // Compare by subtraction
                ctrl.imm = immB;
            end
            default: ;      // Unsupported opcode retires as a no-op
        endcase
    end

endmodule

// ==== rtl/alu.sv ====
`timescale 1ns/1ps

module alu (
    input cpuPkg::word_t a,
    input cpuPkg::word_t b,
    input cpuPkg::aluOp_t op,
    output cpuPkg::word_t result,
    output logic zero
);

    logic lessThan;

    // Signed compare for slt
    assign lessThan = ($signed(a) < $signed(b));

    always_comb begin
        case (op)
            cpuPkg::ALU_ADD: result = a + b;
            cpuPkg::ALU_SUB: result = a - b;
            cpuPkg::ALU_AND: result = a & b;
            cpuPkg::ALU_OR: result = a | b;
            cpuPkg::ALU_XOR: result = a ^ b;
            cpuPkg::ALU_SLT: result = {31'b0, lessThan};
            default: result = a + b;
        endcase
    end

    assign zero = (result == '0);   // Used by beq and bne

endmodule

// ==== rtl/dataMem.sv ====
`timescale 1ns/1ps

module dataMem (
    input logic CLK,
    input cpuPkg::word_t addr,
    input logic we,
    input cpuPkg::word_t wd,
    output cpuPkg::word_t rd
);

    cpuPkg::word_t mem [cpuPkg::DMEM_WORDS];
    logic [29:0] wordIdx;
    logic inRange;

    initial begin
        for (int i = 0; i < cpuPkg::DMEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    assign wordIdx = addr[31:2];
    assign inRange = (wordIdx < 30'(cpuPkg::DMEM_WORDS));

    // Write at the clock edge, out-of-range stores are dropped
    always_ff @(posedge CLK) begin
        if (we && inRange) begin
            mem[wordIdx[cpuPkg::DMEM_AW-1:0]] <= wd;
        end
    end

    // Combinational read
    assign rd = inRange ? mem[wordIdx[cpuPkg::DMEM_AW-1:0]] : '0;

endmodule

// ==== rtl/singleCpu.sv ====
`timescale 1ns/1ps

module singleCpu (
    input logic CLK,
    input logic rst,
    output cpuPkg::word_t instr,
    output cpuPkg::word_t pc,
    output logic wbValid,
    output cpuPkg::regAddr_t wbAddr,
    output cpuPkg::word_t wbData,
    output logic memWrite,
    output cpuPkg::word_t memAddr,
    output cpuPkg::word_t memData
);

    ctrlIf ctrl();

    cpuPkg::word_t nextPc;
    cpuPkg::word_t pcPlus4;
    cpuPkg::word_t pcBranch;
    cpuPkg::word_t rd1;
    cpuPkg::word_t rd2;
    cpuPkg::word_t aluB;
    cpuPkg::word_t aluResult;
    cpuPkg::word_t loadData;
    cpuPkg::regAddr_t rdAddr;
    logic aluZero;
    logic branchTaken;

    // Program counter
    always_ff @(posedge CLK) begin
        if (rst) begin
            pc <= '0;
        end else begin
            pc <= nextPc;
        end
    end

    instMem instMem_i (
        .addr(pc),
        .data(instr)
    );

    decoder decoder_i (
        .instr(instr),
        .ctrl(ctrl.dec)
    );

    assign rdAddr = instr[11:7];

    regFile regFile_i (
        .CLK(CLK),
        .rst(rst),
        .rs1(instr[19:15]),
        .rs2(instr[24:20]),
        .rd(rdAddr),
        .wd(wbData),
        .we(wbValid),
        .rd1(rd1),
        .rd2(rd2)
    );

    assign aluB = ctrl.aluSrc ? ctrl.imm : rd2;    // Operand b select

    alu alu_i (
        .a(rd1),
        .b(aluB),
        .op(ctrl.aluOp),
        .result(aluResult),
        .zero(aluZero)
    );

    dataMem dataMem_i (
        .CLK(CLK),
        .addr(aluResult),
        .we(memWrite),
        .wd(rd2),
        .rd(loadData)
    );

    // Writeback select
    assign wbData = ctrl.memToReg ? loadData : aluResult;

    // beq takes on zero, bne on nonzero
    assign branchTaken = ctrl.branch && (aluZero == !ctrl.branchNe);
    assign pcPlus4 = pc + cpuPkg::PC_STEP;
    assign pcBranch = pc + ctrl.imm;
    assign nextPc = branchTaken ? pcBranch : pcPlus4;

    // Retire trace
    assign wbValid = ctrl.regWrite && (rdAddr != '0) && !rst;
    assign wbAddr = rdAddr;
    assign memWrite = ctrl.memWrite && !rst;
    assign memAddr = aluResult;
    assign memData = rd2;       // Store data comes from rs2

endmodule

// ==== bench/singleCpu_props.sv ====
`timescale 1ns/1ps

module singleCpuProps (
    input logic CLK,
    input logic rst,
    input cpuPkg::word_t pc,
    input logic wbValid,
    input cpuPkg::regAddr_t wbAddr,
    input logic memWrite
);

    // Sampled mid-cycle, once the pc update has settled

    pcAligned: assert property (@(negedge CLK) pc[1:0] == 2'b00)
        else $error("pc %h is not word aligned", pc);

    // A retiring instruction either writes a register or stores, never both
    wbOrStore: assert property (@(negedge CLK) !(wbValid && memWrite))
        else $error("wbValid and memWrite are high together");

    noWbToX0: assert property (@(negedge CLK) wbValid |-> (wbAddr != '0))
        else $error("wbValid is high with wbAddr zero");

    resetPc: assert property (@(negedge CLK) rst |-> (pc == '0))
        else $error("pc is %h during reset", pc);

    resetTrace: assert property (@(negedge CLK) rst |-> (!wbValid && !memWrite))
        else $error("Trace shows a retirement during reset");

endmodule

bind singleCpu singleCpuProps props_i (
    .CLK(CLK),
    .rst(rst),
    .pc(pc),
    .wbValid(wbValid),
    .wbAddr(wbAddr),
    .memWrite(memWrite)
);

// ==== bench/singleCpuTb.sv ====
`timescale 1ns/1ps

module singleCpuTb;

    localparam int RESET_CYCLES = 16;
    localparam int MAX_CYCLES = 500;   // Limit for reaching the final self loop

    logic CLK;
    logic rst;
    cpuPkg::word_t instr;
    cpuPkg::word_t pc;
    logic wbValid;
    cpuPkg::regAddr_t wbAddr;
    cpuPkg::word_t wbData;
    logic memWrite;
    cpuPkg::word_t memAddr;
    cpuPkg::word_t memData;

    // Shadow architectural state
    cpuPkg::word_t regsModel [cpuPkg::NUM_REGS];
    cpuPkg::word_t memModel [cpuPkg::DMEM_WORDS];
    cpuPkg::word_t progModel [cpuPkg::IMEM_WORDS];  // Program image as loaded
    cpuPkg::word_t expPc;

    singleCpu dut_i (
        .CLK(CLK),
        .rst(rst),
        .instr(instr),
        .pc(pc),
        .wbValid(wbValid),
        .wbAddr(wbAddr),
        .wbData(wbData),
        .memWrite(memWrite),
        .memAddr(memAddr),
        .memData(memData)
    );

    always #4 CLK = ~CLK;

    task automatic stopWithFailure();
        $display("Some tests failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic expectEq(input string name, input cpuPkg::word_t exp,
                            input cpuPkg::word_t act);
        assert (act === exp) else begin
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
            stopWithFailure();
        end
    endtask

    // Word the program holds at a byte address, zero past its end
    function automatic cpuPkg::word_t programWord(input cpuPkg::word_t addr);
        if (addr[31:2] < 30'(cpuPkg::IMEM_WORDS)) begin
            return progModel[addr[cpuPkg::IMEM_AW+1:2]];
        end
        return '0;
    endfunction

    // Writes to x0 must not show on the trace
    task automatic checkRegWrite(input cpuPkg::regAddr_t rdIdx, input cpuPkg::word_t value);
        if (rdIdx == '0) begin
            expectEq($sformatf("x0 write suppressed at pc %h", pc), 32'd0, 32'(wbValid));
        end else begin
            expectEq($sformatf("wbValid at pc %h", pc), 32'd1, 32'(wbValid));
            expectEq($sformatf("wbAddr at pc %h", pc), 32'(rdIdx), 32'(wbAddr));
            expectEq($sformatf("wbData at pc %h", pc), value, wbData);
            regsModel[rdIdx] = value;
        end
        expectEq($sformatf("memWrite at pc %h", pc), 32'd0, 32'(memWrite));
    endtask

    // Decode the current instruction, check the trace, then step the model
    task automatic checkRetire();
        logic [6:0] opcode;
        logic [2:0] funct3;
        cpuPkg::regAddr_t rdIdx;
        cpuPkg::regAddr_t rs1Idx;
        cpuPkg::regAddr_t rs2Idx;
        cpuPkg::word_t a;
        cpuPkg::word_t b;
        cpuPkg::word_t opB;
        cpuPkg::word_t immI;
        cpuPkg::word_t immS;
        cpuPkg::word_t immB;
        cpuPkg::word_t result;
        cpuPkg::word_t addr;
        int wordIdx;
        logic taken;

        opcode = instr[6:0];
        funct3 = instr[14:12];
        rdIdx = instr[11:7];
        rs1Idx = instr[19:15];
        rs2Idx = instr[24:20];
        a = regsModel[rs1Idx];
        b = regsModel[rs2Idx];
        immI = {{20{instr[31]}}, instr[31:20]};
        immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        immB = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
        result = '0;
        addr = (opcode == cpuPkg::OP_STORE) ? a + immS : a + immI;
        wordIdx = int'(addr[31:2]);
        expPc = pc + 32'd4;

        case (opcode)
            cpuPkg::OP_RTYPE, cpuPkg::OP_ITYPE: begin
                opB = (opcode == cpuPkg::OP_RTYPE) ? b : immI;
                case (funct3)
                    3'b000: result = (opcode == cpuPkg::OP_RTYPE && instr[30]) ? a - opB : a + opB;
                    3'b010: result = ($signed(a) < $signed(opB)) ? 32'd1 : 32'd0;
                    3'b100: result = a ^ opB;
                    3'b110: result = a | opB;
                    3'b111: result = a & opB;
                    default: begin
                        $display("Program uses an unsupported funct3 at pc %h", pc);
                        stopWithFailure();
                    end
                endcase
                checkRegWrite(rdIdx, result);
            end
            cpuPkg::OP_LOAD, cpuPkg::OP_STORE: begin
                if (addr[1:0] != 2'b00 || wordIdx >= cpuPkg::DMEM_WORDS) begin
                    $display("Program accesses data memory out of range at pc %h", pc);
                    stopWithFailure();
                end
                if (opcode == cpuPkg::OP_LOAD) begin
                    checkRegWrite(rdIdx, memModel[wordIdx]);
                end else begin
                    expectEq($sformatf("store memWrite at pc %h", pc), 32'd1, 32'(memWrite));
                    expectEq($sformatf("store memAddr at pc %h", pc), addr, memAddr);
                    expectEq($sformatf("store memData at pc %h", pc), b, memData);
                    expectEq($sformatf("store wbValid at pc %h", pc), 32'd0, 32'(wbValid));
                    memModel[wordIdx] = b;
                end
            end
            cpuPkg::OP_BRANCH: begin
                if (funct3 != 3'b000 && funct3 != 3'b001) begin
                    $display("Program uses a branch other than beq or bne at pc %h", pc);
                    stopWithFailure();
                end
                taken = (funct3 == 3'b000) ? (a == b) : (a != b);
                if (taken) begin
                    expPc = pc + immB;
                end
                expectEq($sformatf("branch wbValid at pc %h", pc), 32'd0, 32'(wbValid));
                expectEq($sformatf("branch memWrite at pc %h", pc), 32'd0, 32'(memWrite));
            end
            default: begin
                $display("Program holds an unsupported opcode at pc %h", pc);
                stopWithFailure();
            end
        endcase
    endtask

    initial begin
        int cycles;
        logic done;
        cpuPkg::word_t lastPc;

        CLK = 1'b0;
        rst = 1'b1;
        for (int i = 0; i < cpuPkg::NUM_REGS; i++) begin
            regsModel[i] = '0;
        end
        for (int i = 0; i < cpuPkg::DMEM_WORDS; i++) begin
            memModel[i] = '0;
        end
        for (int i = 0; i < cpuPkg::IMEM_WORDS; i++) begin
            progModel[i] = '0;
        end
        $readmemh("program.hex", progModel);
        expPc = '0;         // First fetch comes from pc zero

        // rst is sampled high on 16 rising edges
        for (int i = 1; i < RESET_CYCLES; i++) begin
            @(negedge CLK);
            expectEq("reset pc", 32'd0, pc);
            expectEq("reset wbValid", 32'd0, 32'(wbValid));
            expectEq("reset memWrite", 32'd0, 32'(memWrite));
        end
        @(posedge CLK);
        rst <= 1'b0;

        cycles = 0;
        done = 1'b0;
        lastPc = '1;        // Never a fetched pc
        while (!done && cycles < MAX_CYCLES) begin
            @(negedge CLK);
            cycles++;
            expectEq("next pc", expPc, pc);
            expectEq($sformatf("instr at pc %h", pc), programWord(pc), instr);
            if (pc == lastPc) begin
                done = 1'b1;    // Final self loop reached
            end
            lastPc = pc;
            checkRetire();
        end

        if (!done) begin
            $display("Timeout: program did not reach its final self loop in %0d cycles",
                     MAX_CYCLES);
            stopWithFailure();
        end else begin
            $display("All tests passed");
            $finish;
        end
    end

endmodule

// ==== program.hex ====
// One 32-bit instruction word per line in hex, loaded from address 0
// Text after each word is the assembly it encodes
00500093    // 00: addi x1, x0, 5
FFD00113    // 04: addi x2, x0, -3
002081B3    // 08: add  x3, x1, x2
40110233    // 0C: sub  x4, x2, x1
001222B3    // 10: slt  x5, x4, x1
0020F333    // 14: and  x6, x1, x2
0020E3B3    // 18: or   x7, x1, x2
0020C433    // 1C: xor  x8, x1, x2
00F17493    // 20: andi x9, x2, 15
FF00E513    // 24: ori  x10, x1, -16
FFF24593    // 28: xori x11, x4, -1
00402423    // 2C: sw   x4, 8(x0)
00802603    // 30: lw   x12, 8(x0)
00700013    // 34: addi x0, x0, 7
00208463    // 38: beq  x1, x2, +8   not taken
00461463    // 3C: bne  x12, x4, +8  not taken
00300693    // 40: addi x13, x0, 3
FFF68693    // 44: addi x13, x13, -1
FE069EE3    // 48: bne  x13, x0, -4  loop runs three times
00068463    // 4C: beq  x13, x0, +8  taken
06300713    // 50: addi x14, x0, 99  skipped
00000063    // 54: beq  x0, x0, 0    self loop

// ==== list.f ====
rtl/cpuPkg.sv
rtl/ctrlIf.sv
rtl/instMem.sv
rtl/regFile.sv
rtl/decoder.sv
rtl/alu.sv
rtl/dataMem.sv
rtl/singleCpu.sv
bench/singleCpu_props.sv
bench/singleCpuTb.sv

// ==== Makefile ====
TOP := singleCpuTb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f list.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only -Wall --timing -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir
